// File: cache_way/cache_way.sv
`timescale 1ns/1ps

module cache_way (
	input  logic                               iCLOCK,
	input  logic                               inRESET,
	input  logic                               remove,
	input  l1_cache_pkg::cache_addr_t          rd_addr,
	input  l1_cache_pkg::wr_cmd_t              wr_cmd,
	input  l1_cache_pkg::way_op_t              op,
	input  logic                               advance,
	output logic                               rd_hit,
	output l1_cache_pkg::way_probe_t           probe,
	output logic [l1_cache_pkg::DATA_BITS-1:0] rd_word
);
	import l1_cache_pkg::*;

	localparam int LINE_WORDS = 1 << WORD_BITS;

	logic [TAG_BITS-1:0]  tag_mem  [NUM_SETS];
	logic [1:0]           status   [NUM_SETS];
	logic [DATA_BITS-1:0] data_mem [NUM_SETS * LINE_WORDS];

	logic [SET_BITS-1:0]           rd_set;
	logic [SET_BITS-1:0]           wr_set;
	logic [SET_BITS+WORD_BITS-1:0] rd_index;
	logic [SET_BITS+WORD_BITS-1:0] wr_index;

	assign rd_set   = rd_addr.set;
	assign wr_set   = wr_cmd.addr.set;
	assign rd_index = {rd_addr.set, rd_addr.word};
	assign wr_index = {wr_cmd.addr.set, wr_cmd.addr.word};

	// Read lookup, only a nonzero status counts as valid
	assign rd_hit = (status[rd_set] != 2'd0) && (tag_mem[rd_set] == rd_addr.tag);

	// Replacement view of the write set
	assign probe.match  = tag_mem[wr_set] == wr_cmd.addr.tag;
	assign probe.status = status[wr_set];

	// Tag and data arrays
	always_ff @(posedge iCLOCK) begin
		if (op.write) begin
			tag_mem[wr_set]    <= wr_cmd.addr.tag;
			data_mem[wr_index] <= wr_cmd.data;
		end
	end

	// Word read, held while stalled
	always_ff @(posedge iCLOCK) begin
		if (advance) begin
			rd_word <= data_mem[rd_index];
		end
	end

	// Recency status per line
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				status[i] <= 2'd0;
			end
		end else if (remove) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				status[i] <= 2'd0;   // Flush
			end
		end else begin
			for (int i = 0; i < NUM_SETS; i++) begin
				if (op.write && wr_set == SET_BITS'(i)) begin
					status[i] <= STATUS_MRU;
				end else if (op.set_mru && rd_set == SET_BITS'(i)) begin
					status[i] <= STATUS_MRU;
				end else if (op.age && status[i][1]) begin
					status[i] <= status[i] - 2'd1;   // 3 to 2, 2 to 1
				end
			end
		end
	end

	// Controller keeps the read hit off a line that is being refilled
	a_no_write_mru_clash: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(op.write && op.set_mru && rd_set == wr_set));

	// Reads only touch lines the controller saw hit
	a_mru_needs_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		op.set_mru |-> rd_hit);

endmodule

// File: common/l1_cache_pkg.sv
package l1_cache_pkg;

	// Cache geometry
	localparam int NUM_WAYS  = 4;
	localparam int WAY_BITS  = 2;
	localparam int NUM_SETS  = 16;
	localparam int SET_BITS  = 4;
	localparam int WORD_BITS = 3;   // 8 words per 64-byte line
	localparam int TAG_BITS  = 22;
	localparam int DATA_BITS = 64;

	// Short age period for simulation, tick when all ones
	localparam int AGE_BITS = 6;

	// Status 0 marks an invalid line
	localparam logic [1:0] STATUS_MRU = 2'd3;

	typedef struct packed {
		logic [TAG_BITS-1:0]  tag;
		logic [SET_BITS-1:0]  set;
		logic [WORD_BITS-1:0] word;
		logic [2:0]           byte_off;   // Unused, reads are word wide
	} cache_addr_t;

	typedef struct packed {
		cache_addr_t          addr;
		logic [DATA_BITS-1:0] data;
	} wr_cmd_t;

	// One way's view of the write set
	typedef struct packed {
		logic       match;    // Tag equal, valid or not
		logic [1:0] status;
	} way_probe_t;

	// Per-way control from the controller
	typedef struct packed {
		logic write;
		logic set_mru;   // Read hit on this way
		logic age;
	} way_op_t;

endpackage

// File: dv/l1_cache_model.svh
`ifndef L1_CACHE_MODEL_SVH
`define L1_CACHE_MODEL_SVH

// Expected outcome of one accepted read
typedef struct packed {
	logic                 hit;
	logic                 known;   // Word written since reset
	logic [DATA_BITS-1:0] data;
} rd_result_t;

logic [TAG_BITS-1:0]  m_tag    [NUM_WAYS][NUM_SETS];
logic [1:0]           m_status [NUM_WAYS][NUM_SETS];
logic [DATA_BITS-1:0] m_data   [NUM_WAYS][NUM_SETS][1 << WORD_BITS];
bit                   m_known  [NUM_WAYS][NUM_SETS][1 << WORD_BITS];
logic [AGE_BITS-1:0]  m_timer;

task automatic reset_model();
	m_timer = '0;
	for (int w = 0; w < NUM_WAYS; w++) begin
		for (int s = 0; s < NUM_SETS; s++) begin
			m_tag[w][s]    = '0;   // Stimulus never uses tag zero
			m_status[w][s] = 2'd0;
			for (int k = 0; k < (1 << WORD_BITS); k++) begin
				m_data[w][s][k]  = '0;
				m_known[w][s][k] = 1'b0;
			end
		end
	end
endtask

// First valid way holding the tag, or -1
function automatic int hit_way(input cache_addr_t a);
	for (int w = 0; w < NUM_WAYS; w++) begin
		if (m_status[w][a.set] != 2'd0 && m_tag[w][a.set] == a.tag) begin
			return w;
		end
	end
	return -1;
endfunction

// Same tag first, else the first way of lowest status, else the last way
function automatic int victim_way(input cache_addr_t a);
	int lowest;
	int pick;
	lowest = 3;
	pick   = NUM_WAYS - 1;
	for (int w = 0; w < NUM_WAYS; w++) begin
		if (m_tag[w][a.set] == a.tag) begin
			return w;
		end
	end
	for (int w = 0; w < NUM_WAYS; w++) begin
		if (int'(m_status[w][a.set]) < lowest) begin
			lowest = int'(m_status[w][a.set]);
			pick   = w;
		end
	end
	return pick;
endfunction

// One rising edge of the cache
task automatic step_model(input logic req, input cache_addr_t ra, input logic stall,
		input logic wreq, input wr_cmd_t wc, input logic flush,
		output logic busy, output logic took, output rd_result_t res);
	int   hw;
	int   vw;
	logic tick;
	busy = stall || (req && wreq && ra.set == wc.addr.set && ra.tag == wc.addr.tag);
	took = req && !busy;
	hw   = hit_way(ra);
	res  = '0;
	res.known = 1'b1;   // A miss returns zero
	if (hw >= 0) begin
		res.hit   = 1'b1;
		res.data  = m_data[hw][ra.set][ra.word];
		res.known = m_known[hw][ra.set][ra.word];
	end
	tick = !stall && (&m_timer) && !wreq;
	if (!stall) begin
		m_timer = m_timer + AGE_BITS'(1);
	end
	if (flush) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				m_status[w][s] = 2'd0;
			end
		end
	end else begin
		vw = victim_way(wc.addr);
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				if (wreq && w == vw && s == int'(wc.addr.set)) begin
					m_status[w][s] = STATUS_MRU;   // Write wins its line
				end else if (took && w == hw && s == int'(ra.set)) begin
					m_status[w][s] = STATUS_MRU;
				end else if (tick && m_status[w][s] >= 2'd2) begin
					m_status[w][s] = m_status[w][s] - 2'd1;
				end
			end
		end
		if (wreq) begin
			m_tag[vw][wc.addr.set]                = wc.addr.tag;
			m_data[vw][wc.addr.set][wc.addr.word]  = wc.data;
			m_known[vw][wc.addr.set][wc.addr.word] = 1'b1;
		end
	end
endtask

`endif

// File: dv/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;
	import l1_cache_pkg::*;

	localparam int N_OPS        = 3000;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_CYCLES   = 4 * N_OPS + RESET_CYCLES;
	localparam int NUM_TAGS     = 6;

	logic                 iCLOCK;
	logic                 inRESET;
	logic                 remove;
	logic                 rd_req;
	cache_addr_t          rd_addr;
	logic                 rd_busy;
	logic                 rd_stall;
	logic                 rd_valid;
	logic                 rd_hit;
	logic [DATA_BITS-1:0] rd_data;
	logic                 wr_req;
	wr_cmd_t              wr_cmd;

	`include "l1_cache_model.svh"

	integer     seed;
	int         errors;
	int         reads_checked;
	int         cycles;
	logic       hold_read;   // Last read was refused
	rd_result_t pending[$];

	l1_cache_top u_dut (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.remove   (remove),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_busy  (rd_busy),
		.rd_stall (rd_stall),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_data  (rd_data),
		.wr_req   (wr_req),
		.wr_cmd   (wr_cmd)
	);

	always #50 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Two sets and six tags keep hits and evictions frequent
	function automatic cache_addr_t random_addr();
		cache_addr_t a;
		int          pick;
		pick       = {$random(seed)} % NUM_TAGS;
		a.tag      = TAG_BITS'(22'h2A5 + pick * 22'h1F3);
		a.set      = ($random(seed) & 1) ? 4'd5 : 4'd12;
		a.word     = WORD_BITS'($random(seed));
		a.byte_off = 3'($random(seed));
		return a;
	endfunction

	task automatic drive_inputs(input int op);
		logic [31:0] r;
		r        = $random(seed);
		rd_stall = r[3:0] < 4'd2;
		remove   = !hold_read && op > 40 && r[11:4] == 8'd0;   // Rare flush
		if (hold_read) begin
			rd_req = 1'b1;   // Retry with the same address
		end else begin
			rd_req  = !remove && r[13:12] != 2'd0;
			rd_addr = random_addr();
		end
		// Reads only at first so the cache starts out empty
		wr_req       = !remove && op >= 24 && r[16:14] < 3'd3;
		wr_cmd.addr  = random_addr();
		wr_cmd.data  = {$random(seed), $random(seed)};
	endtask

	task automatic check_edge();
		logic       exp_valid;
		logic       busy;
		logic       took;
		rd_result_t exp;
		rd_result_t res;
		exp_valid = pending.size() != 0 && !rd_stall;
		assert (rd_valid === exp_valid) else begin
			errors++;
			$display("FAILED at %0t ns: rd_valid %b, expected %b", $time, rd_valid, exp_valid);
		end
		if (exp_valid) begin
			exp = pending.pop_front();
			reads_checked++;
			assert (rd_hit === exp.hit) else begin
				errors++;
				$display("FAILED at %0t ns: rd_hit %b, expected %b", $time, rd_hit, exp.hit);
			end
			assert (!exp.known || rd_data === exp.data) else begin
				errors++;
				$display("FAILED at %0t ns: rd_data %h, expected %h", $time, rd_data, exp.data);
			end
		end
		step_model(rd_req, rd_addr, rd_stall, wr_req, wr_cmd, remove, busy, took, res);
		assert (rd_busy === busy) else begin
			errors++;
			$display("FAILED at %0t ns: rd_busy %b, expected %b", $time, rd_busy, busy);
		end
		hold_read = rd_req && busy;
		if (remove) begin
			pending.delete();   // Flush drops the read in flight
		end else if (took) begin
			pending.push_back(res);
		end
	endtask

	initial begin
		seed          = 32'h3766;
		errors        = 0;
		reads_checked = 0;
		cycles        = 0;
		hold_read     = 1'b0;
		iCLOCK        = 1'b0;
		inRESET       = 1'b0;
		remove        = 1'b0;
		rd_req        = 1'b0;
		rd_addr       = '0;
		rd_stall      = 1'b0;
		wr_req        = 1'b0;
		wr_cmd        = '0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		for (int op = 0; op < N_OPS; op++) begin
			drive_inputs(op);
			@(posedge iCLOCK);
			check_edge();
			@(negedge iCLOCK);
		end
		// Quiet inputs while the last result drains
		rd_req   = 1'b0;
		wr_req   = 1'b0;
		rd_stall = 1'b0;
		remove   = 1'b0;
		repeat (2) begin
			@(posedge iCLOCK);
			check_edge();
			@(negedge iCLOCK);
		end
		$display("Run complete, %0d reads checked, %0d errors", reads_checked, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: hw/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top (
	input  logic                               iCLOCK,
	input  logic                               inRESET,
	input  logic                               remove,
	input  logic                               rd_req,
	input  l1_cache_pkg::cache_addr_t          rd_addr,
	output logic                               rd_busy,
	input  logic                               rd_stall,
	output logic                               rd_valid,
	output logic                               rd_hit,
	output logic [l1_cache_pkg::DATA_BITS-1:0] rd_data,
	input  logic                               wr_req,
	input  l1_cache_pkg::wr_cmd_t              wr_cmd
);
	import l1_cache_pkg::*;

	logic                                take;
	logic                                advance;
	logic [NUM_WAYS-1:0]                 way_hit;
	way_probe_t [NUM_WAYS-1:0]           probe;
	way_op_t [NUM_WAYS-1:0]              op;
	logic [NUM_WAYS-1:0][DATA_BITS-1:0]  way_word;

	// Handshake, replacement and aging
	way_ctrl u_ctrl (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.remove   (remove),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_stall (rd_stall),
		.wr_req   (wr_req),
		.wr_cmd   (wr_cmd),
		.rd_hit   (way_hit),
		.probe    (probe),
		.op       (op),
		.rd_busy  (rd_busy),
		.take     (take),
		.advance  (advance)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_way u_way (
			.iCLOCK  (iCLOCK),
			.inRESET (inRESET),
			.remove  (remove),
			.rd_addr (rd_addr),
			.wr_cmd  (wr_cmd),
			.op      (op[w]),
			.advance (advance),
			.rd_hit  (way_hit[w]),
			.probe   (probe[w]),
			.rd_word (way_word[w])
		);
	end

	// Output stage
	read_return u_ret (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.remove   (remove),
		.take     (take),
		.advance  (advance),
		.way_hit  (way_hit),
		.rd_word  (way_word),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_data  (rd_data)
	);

endmodule

// File: hw/read_return.sv
`timescale 1ns/1ps

module read_return (
	input  logic                                                         iCLOCK,
	input  logic                                                         inRESET,
	input  logic                                                         remove,
	input  logic                                                         take,
	input  logic                                                         advance,
	input  logic [l1_cache_pkg::NUM_WAYS-1:0]                            way_hit,
	input  logic [l1_cache_pkg::NUM_WAYS-1:0][l1_cache_pkg::DATA_BITS-1:0] rd_word,
	output logic                                                         rd_valid,
	output logic                                                         rd_hit,
	output logic [l1_cache_pkg::DATA_BITS-1:0]                           rd_data
);
	import l1_cache_pkg::*;

	logic                 take_q;
	logic [NUM_WAYS-1:0]  hit_q;
	logic [DATA_BITS-1:0] hit_word;

	// Lines up with the word registers inside the ways
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			take_q <= 1'b0;
			hit_q  <= '0;
		end else if (remove) begin
			take_q <= 1'b0;   // Drop the read in flight
			hit_q  <= '0;
		end else if (advance) begin
			take_q <= take;
			hit_q  <= way_hit;
		end
	end

	// At most one way hits, so an OR of the masked words is enough
	always_comb begin
		hit_word = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				hit_word = hit_word | rd_word[w];
			end
		end
	end

	assign rd_valid = take_q && advance;   // Low while back-pressured
	assign rd_hit   = rd_valid && (|hit_q);
	assign rd_data  = rd_hit ? hit_word : '0;

	// Fills reuse the way that already holds the tag, so one tag per set
	a_hit_onehot: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0(hit_q));

endmodule

// File: hw/way_ctrl.sv
`timescale 1ns/1ps

module way_ctrl (
	input  logic                                           iCLOCK,
	input  logic                                           inRESET,
	input  logic                                           remove,
	input  logic                                           rd_req,
	input  l1_cache_pkg::cache_addr_t                      rd_addr,
	input  logic                                           rd_stall,
	input  logic                                           wr_req,
	input  l1_cache_pkg::wr_cmd_t                          wr_cmd,
	input  logic [l1_cache_pkg::NUM_WAYS-1:0]              rd_hit,
	input  l1_cache_pkg::way_probe_t [l1_cache_pkg::NUM_WAYS-1:0] probe,
	output l1_cache_pkg::way_op_t [l1_cache_pkg::NUM_WAYS-1:0]    op,
	output logic                                           rd_busy,
	output logic                                           take,
	output logic                                           advance
);
	import l1_cache_pkg::*;

	logic [AGE_BITS-1:0] age_timer;
	logic                age_tick;
	logic                same_set;
	logic [WAY_BITS-1:0] wr_way;
	logic [NUM_WAYS-1:0] wr_sel;
	logic [NUM_WAYS-1:0] first_hit;
	logic                any_match;
	logic [1:0]          min_status;

	// Matching tag first, then lowest status in way order
	function automatic logic [WAY_BITS-1:0] pick_way(input way_probe_t [NUM_WAYS-1:0] p);
		logic [WAY_BITS-1:0] sel;
		logic                found;
		sel   = WAY_BITS'(NUM_WAYS - 1);
		found = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!found && p[w].match) begin
				sel   = WAY_BITS'(w);
				found = 1'b1;
			end
		end
		for (int lvl = 0; lvl < 3; lvl++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!found && p[w].status == 2'(lvl)) begin
					sel   = WAY_BITS'(w);
					found = 1'b1;
				end
			end
		end
		return sel;
	endfunction

	assign same_set = rd_addr.set == wr_cmd.addr.set;
	assign advance  = !rd_stall;
	assign rd_busy  = rd_stall ||
		(rd_req && wr_req && same_set && rd_addr.tag == wr_cmd.addr.tag);
	assign take     = rd_req && !rd_busy;

	// Pauses under back-pressure and keeps counting through a flush
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer <= '0;
		end else if (advance) begin
			age_timer <= age_timer + 1'b1;
		end
	end

	assign age_tick  = advance && (&age_timer) && !wr_req;   // Lost when a write lands
	assign wr_way    = pick_way(probe);
	assign first_hit = rd_hit & (~rd_hit + 1'b1);

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			wr_sel[w]     = wr_req && !remove && wr_way == WAY_BITS'(w);
			op[w].write   = wr_sel[w];
			// Write owns the line when both land on it
			op[w].set_mru = take && !remove && first_hit[w] && !(wr_sel[w] && same_set);
			op[w].age     = age_tick && !remove;
		end
	end

	// Lowest status in the write set and whether any way holds the tag
	always_comb begin
		any_match  = 1'b0;
		min_status = STATUS_MRU;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (probe[w].match) begin
				any_match = 1'b1;
			end
			if (probe[w].status < min_status) begin
				min_status = probe[w].status;
			end
		end
	end

	// A write reuses the way holding its tag, otherwise a way of the lowest status
	a_write_way_rule: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		wr_req && !remove |->
		(any_match ? probe[wr_way].match : probe[wr_way].status == min_status));

endmodule

// File: l1_cache.f
+incdir+dv
common/l1_cache_pkg.sv
cache_way/cache_way.sv
hw/way_ctrl.sv
hw/read_return.sv
hw/l1_cache_top.sv
dv/tb_l1_cache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_l1_cache \
	-f l1_cache.f -o tb_l1_cache > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_l1_cache > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
